// ==== hdl/axi_addr_decoder.sv ====
`timescale 1ns/1ps

module axi_addr_decoder #(
    parameter int NUM_BANKS      = 4,
    parameter int WORDS_PER_BANK = 64
) (
    input  logic                              clk,
    input  logic                              rst,
    input  sram_axi_pkg::addr_t               saxi_araddr,
    input  logic                              saxi_arvalid,
    output logic                              saxi_arready,
    input  sram_axi_pkg::addr_t               saxi_awaddr,
    input  logic                              saxi_awvalid,
    output logic                              saxi_awready,
    input  sram_axi_pkg::data_t               saxi_wdata,
    input  sram_axi_pkg::strb_t               saxi_wstrb,
    input  logic                              saxi_wvalid,
    output logic                              saxi_wready,
    output logic [$clog2(WORDS_PER_BANK)-1:0] bank_araddr_row,
    output logic [NUM_BANKS-1:0]              bank_arvalid,
    input  logic [NUM_BANKS-1:0]              bank_arready,
    output logic [$clog2(WORDS_PER_BANK)-1:0] bank_awaddr_row,
    output logic [NUM_BANKS-1:0]              bank_awvalid,
    input  logic [NUM_BANKS-1:0]              bank_awready,
    output sram_axi_pkg::data_t               bank_wdata,
    output sram_axi_pkg::strb_t               bank_wstrb,
    output logic [NUM_BANKS-1:0]              bank_wvalid,
    input  logic [NUM_BANKS-1:0]              bank_wready,
    output logic [$clog2(NUM_BANKS)-1:0]      rd_sel,
    output logic                              rd_err,
    output logic [$clog2(NUM_BANKS)-1:0]      wr_sel,
    output logic                              wr_err,
    input  logic                              rd_done,
    input  logic                              wr_done
);
    import sram_axi_pkg::*;

    localparam int    SEL_W        = $clog2(NUM_BANKS);
    localparam int    ROW_W        = $clog2(WORDS_PER_BANK);
    localparam addr_t REGION_WORDS = addr_t'(NUM_BANKS * WORDS_PER_BANK);

    addr_t            ar_idx;
    addr_t            aw_idx;
    logic             ar_oor;
    logic             aw_oor;
    logic [SEL_W-1:0] ar_bank;
    logic [SEL_W-1:0] aw_bank;
    logic             ar_fire;
    logic             aw_fire;
    logic             w_fire;
    logic             w_open;
    logic [SEL_W-1:0] cur_wsel;
    logic             cur_werr;
    logic             rd_busy;
    logic             wr_busy;
    logic             wr_err_q;
    logic             w_got;

    function automatic addr_t word_index(input addr_t a);
        return (a - REGION_BASE) >> 2;
    endfunction

    function automatic logic out_of_range(input addr_t a);
        return (a < REGION_BASE) || (word_index(a) >= REGION_WORDS);
    endfunction

    // low word index bits pick the bank and the next ones the row
    assign ar_idx          = word_index(saxi_araddr);
    assign ar_oor          = out_of_range(saxi_araddr);
    assign ar_bank         = ar_idx[SEL_W-1:0];
    assign bank_araddr_row = ar_idx[SEL_W +: ROW_W];
    assign aw_idx          = word_index(saxi_awaddr);
    assign aw_oor          = out_of_range(saxi_awaddr);
    assign aw_bank         = aw_idx[SEL_W-1:0];
    assign bank_awaddr_row = aw_idx[SEL_W +: ROW_W];

    // the addressed bank gives ready and the decoder takes a decode error itself
    assign saxi_arready = !rd_busy && (ar_oor || bank_arready[ar_bank]);
    assign saxi_awready = !wr_busy && (aw_oor || bank_awready[aw_bank]);
    assign ar_fire      = saxi_arvalid && saxi_arready;
    assign aw_fire      = saxi_awvalid && saxi_awready;

    // W follows the bank of the current AW, or the latched one
    assign cur_wsel    = aw_fire ? aw_bank : wr_sel;
    assign cur_werr    = aw_fire ? aw_oor : wr_err_q;
    assign w_open      = (aw_fire || wr_busy) && !w_got;
    assign saxi_wready = w_open && (cur_werr || bank_wready[cur_wsel]);
    assign w_fire      = saxi_wvalid && saxi_wready;
    assign bank_wdata  = saxi_wdata;
    assign bank_wstrb  = saxi_wstrb;

    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            bank_arvalid[i] = ar_fire && !ar_oor && (ar_bank == SEL_W'(i));
            bank_awvalid[i] = aw_fire && !aw_oor && (aw_bank == SEL_W'(i));
            bank_wvalid[i]  = saxi_wvalid && w_open && !cur_werr && (cur_wsel == SEL_W'(i));
        end
    end

    // error strobes are high in the cycle the failing request completes
    assign rd_err = ar_fire && ar_oor;
    assign wr_err = w_fire && cur_werr;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_busy  <= 1'b0;
            rd_sel   <= '0;
            wr_busy  <= 1'b0;
            wr_sel   <= '0;
            wr_err_q <= 1'b0;
            w_got    <= 1'b0;
        end else begin
            if (ar_fire) begin
                rd_busy <= 1'b1;
                rd_sel  <= ar_bank;
            end else if (rd_done) begin
                rd_busy <= 1'b0;
            end
            if (aw_fire) begin
                wr_busy  <= 1'b1;
                wr_sel   <= aw_bank;
                wr_err_q <= aw_oor;
            end else if (wr_done) begin
                wr_busy <= 1'b0;
            end
            if (w_fire) begin
                w_got <= 1'b1;
            end else if (wr_done) begin
                w_got <= 1'b0;
            end
        end
    end

endmodule

// ==== hdl/axi_resp_merger.sv ====
`timescale 1ns/1ps

module axi_resp_merger #(
    parameter int NUM_BANKS = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [NUM_BANKS-1:0]                bank_rvalid,
    input  sram_axi_pkg::data_t [NUM_BANKS-1:0] bank_rdata,
    input  logic [NUM_BANKS-1:0]                bank_bvalid,
    output logic [NUM_BANKS-1:0]                bank_rready,
    output logic [NUM_BANKS-1:0]                bank_bready,
    input  logic [$clog2(NUM_BANKS)-1:0]        rd_sel,
    input  logic                                rd_err,
    input  logic [$clog2(NUM_BANKS)-1:0]        wr_sel,
    input  logic                                wr_err,
    output logic                                rd_done,
    output logic                                wr_done,
    output sram_axi_pkg::data_t                 saxi_rdata,
    output sram_axi_pkg::resp_t                 saxi_rresp,
    output logic                                saxi_rvalid,
    input  logic                                saxi_rready,
    output sram_axi_pkg::resp_t                 saxi_bresp,
    output logic                                saxi_bvalid,
    input  logic                                saxi_bready
);
    import sram_axi_pkg::*;

    logic rd_take;
    logic wr_take;

    // only the owning bank sees ready, and only while the output is empty
    always_comb begin
        bank_rready = '0;
        bank_bready = '0;
        if (!saxi_rvalid) begin
            bank_rready[rd_sel] = 1'b1;
        end
        if (!saxi_bvalid) begin
            bank_bready[wr_sel] = 1'b1;
        end
    end

    assign rd_take = !saxi_rvalid && bank_rvalid[rd_sel];
    assign wr_take = !saxi_bvalid && bank_bvalid[wr_sel];
    assign rd_done = saxi_rvalid && saxi_rready;
    assign wr_done = saxi_bvalid && saxi_bready;

    always_ff @(posedge clk) begin
        if (rst) begin
            saxi_rvalid <= 1'b0;
            saxi_bvalid <= 1'b0;
        end else begin
            if (rd_err || rd_take) begin
                saxi_rvalid <= 1'b1;
            end else if (rd_done) begin
                saxi_rvalid <= 1'b0;
            end
            if (wr_err || wr_take) begin
                saxi_bvalid <= 1'b1;
            end else if (wr_done) begin
                saxi_bvalid <= 1'b0;
            end
        end
    end

    // decode errors return zero data
    always_ff @(posedge clk) begin
        if (rd_err) begin
            saxi_rdata <= '0;
            saxi_rresp <= RESP_DECERR;
        end else if (rd_take) begin
            saxi_rdata <= bank_rdata[rd_sel];
            saxi_rresp <= RESP_OKAY;
        end
        if (wr_err) begin
            saxi_bresp <= RESP_DECERR;
        end else if (wr_take) begin
            saxi_bresp <= RESP_OKAY;
        end
    end

endmodule

// ==== hdl/sram_axi_pkg.sv ====
package sram_axi_pkg;

    // byte address on the slave port
    typedef logic [31:0] addr_t;

    // one data word, same width for every bank
    typedef logic [31:0] data_t;

    // one strobe bit per byte lane
    typedef logic [3:0] strb_t;

    // AXI response code
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // start of the SRAM region, matches the core reset address
    localparam addr_t REGION_BASE = 32'h8000_0000;

endpackage

// ==== hdl/sram_axi_top.sv ====
`timescale 1ns/1ps

module sram_axi_top #(
    parameter int NUM_BANKS      = 4,
    parameter int WORDS_PER_BANK = 64
) (
    input  logic                clk,
    input  logic                rst,
    input  sram_axi_pkg::addr_t saxi_araddr,
    input  logic                saxi_arvalid,
    output logic                saxi_arready,
    output sram_axi_pkg::data_t saxi_rdata,
    output sram_axi_pkg::resp_t saxi_rresp,
    output logic                saxi_rvalid,
    input  logic                saxi_rready,
    input  sram_axi_pkg::addr_t saxi_awaddr,
    input  logic                saxi_awvalid,
    output logic                saxi_awready,
    input  sram_axi_pkg::data_t saxi_wdata,
    input  sram_axi_pkg::strb_t saxi_wstrb,
    input  logic                saxi_wvalid,
    output logic                saxi_wready,
    output sram_axi_pkg::resp_t saxi_bresp,
    output logic                saxi_bvalid,
    input  logic                saxi_bready
);
    import sram_axi_pkg::*;

    localparam int SEL_W = $clog2(NUM_BANKS);
    localparam int ROW_W = $clog2(WORDS_PER_BANK);

    logic [ROW_W-1:0]            bank_araddr_row;
    logic [ROW_W-1:0]            bank_awaddr_row;
    data_t                       bank_wdata;
    strb_t                       bank_wstrb;
    logic [NUM_BANKS-1:0]        bank_arvalid;
    logic [NUM_BANKS-1:0]        bank_arready;
    logic [NUM_BANKS-1:0]        bank_awvalid;
    logic [NUM_BANKS-1:0]        bank_awready;
    logic [NUM_BANKS-1:0]        bank_wvalid;
    logic [NUM_BANKS-1:0]        bank_wready;
    logic [NUM_BANKS-1:0]        bank_rvalid;
    logic [NUM_BANKS-1:0]        bank_rready;
    data_t [NUM_BANKS-1:0]       bank_rdata;
    logic [NUM_BANKS-1:0]        bank_bvalid;
    logic [NUM_BANKS-1:0]        bank_bready;
    logic [SEL_W-1:0]            rd_sel;
    logic [SEL_W-1:0]            wr_sel;
    logic                        rd_err;
    logic                        wr_err;
    logic                        rd_done;
    logic                        wr_done;

    axi_addr_decoder #(
        .NUM_BANKS      (NUM_BANKS),
        .WORDS_PER_BANK (WORDS_PER_BANK)
    ) u_decoder (
        .clk             (clk),
        .rst             (rst),
        .saxi_araddr     (saxi_araddr),
        .saxi_arvalid    (saxi_arvalid),
        .saxi_arready    (saxi_arready),
        .saxi_awaddr     (saxi_awaddr),
        .saxi_awvalid    (saxi_awvalid),
        .saxi_awready    (saxi_awready),
        .saxi_wdata      (saxi_wdata),
        .saxi_wstrb      (saxi_wstrb),
        .saxi_wvalid     (saxi_wvalid),
        .saxi_wready     (saxi_wready),
        .bank_araddr_row (bank_araddr_row),
        .bank_arvalid    (bank_arvalid),
        .bank_arready    (bank_arready),
        .bank_awaddr_row (bank_awaddr_row),
        .bank_awvalid    (bank_awvalid),
        .bank_awready    (bank_awready),
        .bank_wdata      (bank_wdata),
        .bank_wstrb      (bank_wstrb),
        .bank_wvalid     (bank_wvalid),
        .bank_wready     (bank_wready),
        .rd_sel          (rd_sel),
        .rd_err          (rd_err),
        .wr_sel          (wr_sel),
        .wr_err          (wr_err),
        .rd_done         (rd_done),
        .wr_done         (wr_done)
    );

    // word interleaved banks
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        sram_bank_slave #(
            .WORDS_PER_BANK (WORDS_PER_BANK)
        ) u_bank (
            .clk        (clk),
            .rst        (rst),
            .arvalid    (bank_arvalid[i]),
            .araddr_row (bank_araddr_row),
            .arready    (bank_arready[i]),
            .rvalid     (bank_rvalid[i]),
            .rdata      (bank_rdata[i]),
            .rready     (bank_rready[i]),
            .awvalid    (bank_awvalid[i]),
            .awaddr_row (bank_awaddr_row),
            .awready    (bank_awready[i]),
            .wvalid     (bank_wvalid[i]),
            .wdata      (bank_wdata),
            .wstrb      (bank_wstrb),
            .wready     (bank_wready[i]),
            .bvalid     (bank_bvalid[i]),
            .bready     (bank_bready[i])
        );
    end

    axi_resp_merger #(
        .NUM_BANKS (NUM_BANKS)
    ) u_merger (
        .clk         (clk),
        .rst         (rst),
        .bank_rvalid (bank_rvalid),
        .bank_rdata  (bank_rdata),
        .bank_bvalid (bank_bvalid),
        .bank_rready (bank_rready),
        .bank_bready (bank_bready),
        .rd_sel      (rd_sel),
        .rd_err      (rd_err),
        .wr_sel      (wr_sel),
        .wr_err      (wr_err),
        .rd_done     (rd_done),
        .wr_done     (wr_done),
        .saxi_rdata  (saxi_rdata),
        .saxi_rresp  (saxi_rresp),
        .saxi_rvalid (saxi_rvalid),
        .saxi_rready (saxi_rready),
        .saxi_bresp  (saxi_bresp),
        .saxi_bvalid (saxi_bvalid),
        .saxi_bready (saxi_bready)
    );

endmodule

// ==== hdl/sram_bank_array.sv ====
`timescale 1ns/1ps

module sram_bank_array #(
    parameter int WORDS_PER_BANK = 64
) (
    input  logic                              clk,
    input  logic                              rd_en,
    input  logic [$clog2(WORDS_PER_BANK)-1:0] rd_row,
    output sram_axi_pkg::data_t               rd_data,
    input  logic                              wr_en,
    input  logic [$clog2(WORDS_PER_BANK)-1:0] wr_row,
    input  sram_axi_pkg::data_t               wr_data,
    input  sram_axi_pkg::strb_t               wr_strb
);
    import sram_axi_pkg::*;

    localparam int LANES = $bits(strb_t);

    data_t mem [WORDS_PER_BANK];

    // registered read, output holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_row];
        end
    end

    // byte lane write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < LANES; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_row][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== hdl/sram_bank_slave.sv ====
`timescale 1ns/1ps

module sram_bank_slave #(
    parameter int WORDS_PER_BANK = 64
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              arvalid,
    input  logic [$clog2(WORDS_PER_BANK)-1:0] araddr_row,
    output logic                              arready,
    output logic                              rvalid,
    output sram_axi_pkg::data_t               rdata,
    input  logic                              rready,
    input  logic                              awvalid,
    input  logic [$clog2(WORDS_PER_BANK)-1:0] awaddr_row,
    output logic                              awready,
    input  logic                              wvalid,
    input  sram_axi_pkg::data_t               wdata,
    input  sram_axi_pkg::strb_t               wstrb,
    output logic                              wready,
    output logic                              bvalid,
    input  logic                              bready
);
    import sram_axi_pkg::*;

    localparam int ROW_W = $clog2(WORDS_PER_BANK);

    logic             ar_fire;
    logic             r_fire;
    logic             aw_fire;
    logic             w_fire;
    logic             b_fire;
    logic             aw_held;
    logic             w_held;
    logic             wr_go;
    logic [ROW_W-1:0] aw_row_q;
    logic [ROW_W-1:0] wr_row;
    data_t            wdata_q;
    data_t            wr_data;
    strb_t            wstrb_q;
    strb_t            wr_strb;

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;

    // read side: one read in flight, data comes straight from the array
    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b1;
            rvalid  <= 1'b0;
        end else if (ar_fire) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;
        end else if (r_fire) begin
            arready <= 1'b1;
            rvalid  <= 1'b0;
        end
    end

    // write fires once address and data are both present,
    // either held from an earlier cycle or arriving now
    assign wr_go   = (aw_held || aw_fire) && (w_held || w_fire);
    assign wr_row  = aw_fire ? awaddr_row : aw_row_q;
    assign wr_data = w_fire ? wdata : wdata_q;
    assign wr_strb = w_fire ? wstrb : wstrb_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b1;
            wready  <= 1'b1;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            // readiness comes back only after the B transfer
            if (aw_fire) begin
                awready <= 1'b0;
            end else if (b_fire) begin
                awready <= 1'b1;
            end
            if (w_fire) begin
                wready <= 1'b0;
            end else if (b_fire) begin
                wready <= 1'b1;
            end
            if (wr_go) begin
                aw_held <= 1'b0;
            end else if (aw_fire) begin
                aw_held <= 1'b1;
            end
            if (wr_go) begin
                w_held <= 1'b0;
            end else if (w_fire) begin
                w_held <= 1'b1;
            end
            if (wr_go) begin
                bvalid <= 1'b1;
            end else if (b_fire) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            aw_row_q <= awaddr_row;
        end
        if (w_fire) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
    end

    sram_bank_array #(
        .WORDS_PER_BANK (WORDS_PER_BANK)
    ) u_array (
        .clk     (clk),
        .rd_en   (ar_fire),
        .rd_row  (araddr_row),
        .rd_data (rdata),
        .wr_en   (wr_go),
        .wr_row  (wr_row),
        .wr_data (wr_data),
        .wr_strb (wr_strb)
    );

endmodule

// ==== sram_axi_top.f ====
hdl/sram_axi_pkg.sv
hdl/sram_bank_array.sv
hdl/sram_bank_slave.sv
hdl/axi_addr_decoder.sv
hdl/axi_resp_merger.sv
hdl/sram_axi_top.sv
verification/tb_sram_axi_top.sv

// ==== verification/tb_sram_axi_top.sv ====
`timescale 1ns/1ps

module tb_sram_axi_top;
    import sram_axi_pkg::*;

    localparam int NUM_BANKS      = 4;
    localparam int WORDS_PER_BANK = 64;
    localparam int NUM_WORDS      = NUM_BANKS * WORDS_PER_BANK;
    localparam int TIMEOUT        = 100;

    logic  clk;
    logic  rst;
    addr_t saxi_araddr;
    logic  saxi_arvalid;
    logic  saxi_arready;
    data_t saxi_rdata;
    resp_t saxi_rresp;
    logic  saxi_rvalid;
    logic  saxi_rready;
    addr_t saxi_awaddr;
    logic  saxi_awvalid;
    logic  saxi_awready;
    data_t saxi_wdata;
    strb_t saxi_wstrb;
    logic  saxi_wvalid;
    logic  saxi_wready;
    resp_t saxi_bresp;
    logic  saxi_bvalid;
    logic  saxi_bready;

    // expected memory with one entry per byte address
    logic [7:0] ref_mem [addr_t];
    string      test_name;
    int         errors;
    int         tests_run;
    int         seed;
    event       timed_out;

    sram_axi_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .saxi_araddr  (saxi_araddr),
        .saxi_arvalid (saxi_arvalid),
        .saxi_arready (saxi_arready),
        .saxi_rdata   (saxi_rdata),
        .saxi_rresp   (saxi_rresp),
        .saxi_rvalid  (saxi_rvalid),
        .saxi_rready  (saxi_rready),
        .saxi_awaddr  (saxi_awaddr),
        .saxi_awvalid (saxi_awvalid),
        .saxi_awready (saxi_awready),
        .saxi_wdata   (saxi_wdata),
        .saxi_wstrb   (saxi_wstrb),
        .saxi_wvalid  (saxi_wvalid),
        .saxi_wready  (saxi_wready),
        .saxi_bresp   (saxi_bresp),
        .saxi_bvalid  (saxi_bvalid),
        .saxi_bready  (saxi_bready)
    );

    always #10 clk = ~clk;

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
        errors++;
    endtask

    task automatic give_up(input string what);
        errors++;
        $display("timeout in %s: %s", test_name, what);
        -> timed_out;
    endtask

    task automatic model_write(input addr_t addr, input data_t data, input strb_t strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                ref_mem[addr_t'(addr + b)] = data[8*b +: 8];
            end
        end
    endtask

    function automatic data_t model_read(input addr_t addr);
        data_t w;
        w = 'x;
        for (int b = 0; b < 4; b++) begin
            if (ref_mem.exists(addr_t'(addr + b))) begin
                w[8*b +: 8] = ref_mem[addr_t'(addr + b)];
            end
        end
        return w;
    endfunction

    // AW and W are offered together and latency counts from the later transfer
    task automatic axi_write(input addr_t addr, input data_t data, input strb_t strb,
                             input int bdelay, output resp_t resp, output int lat);
        int n;
        bit aw_ok;
        bit w_ok;
        saxi_awaddr  <= addr;
        saxi_awvalid <= 1'b1;
        saxi_wdata   <= data;
        saxi_wstrb   <= strb;
        saxi_wvalid  <= 1'b1;
        aw_ok = 1'b0;
        w_ok  = 1'b0;
        n     = 0;
        while (!(aw_ok && w_ok)) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) give_up("write address or data was never accepted");
            if (saxi_awvalid && saxi_awready) begin
                aw_ok = 1'b1;
                saxi_awvalid <= 1'b0;
            end
            if (saxi_wvalid && saxi_wready) begin
                w_ok = 1'b1;
                saxi_wvalid <= 1'b0;
            end
        end
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
            if (lat > TIMEOUT) give_up("no write response");
        end while (!saxi_bvalid);
        resp = saxi_bresp;
        // master stalls the B channel
        repeat (bdelay) begin
            @(posedge clk);
            if (saxi_bvalid !== 1'b1) report_mismatch("bvalid held", 1, saxi_bvalid);
            if (saxi_bresp !== resp) report_mismatch("bresp held", resp, saxi_bresp);
            if (saxi_awready !== 1'b0) report_mismatch("awready in stall", 0, saxi_awready);
        end
        saxi_bready <= 1'b1;
        @(posedge clk);
        saxi_bready <= 1'b0;
    endtask

    task automatic axi_read(input addr_t addr, input int rdelay,
                            output data_t data, output resp_t resp, output int lat);
        int n;
        saxi_araddr  <= addr;
        saxi_arvalid <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) give_up("read address was never accepted");
        end while (!saxi_arready);
        saxi_arvalid <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
            if (lat > TIMEOUT) give_up("no read response");
        end while (!saxi_rvalid);
        data = saxi_rdata;
        resp = saxi_rresp;
        repeat (rdelay) begin
            @(posedge clk);
            if (saxi_rvalid !== 1'b1) report_mismatch("rvalid held", 1, saxi_rvalid);
            if (saxi_rdata !== data) report_mismatch("rdata held", data, saxi_rdata);
            if (saxi_rresp !== resp) report_mismatch("rresp held", resp, saxi_rresp);
            if (saxi_arready !== 1'b0) report_mismatch("arready in stall", 0, saxi_arready);
        end
        saxi_rready <= 1'b1;
        @(posedge clk);
        saxi_rready <= 1'b0;
    endtask

    // in range gives OKAY after 2 cycles and out of range DECERR after 1
    task automatic write_check(input addr_t addr, input data_t data, input strb_t strb,
                               input bit in_range, input int bdelay);
        resp_t r;
        int    lat;
        resp_t exp_resp;
        int    exp_lat;
        exp_resp = in_range ? RESP_OKAY : RESP_DECERR;
        exp_lat  = in_range ? 2 : 1;
        axi_write(addr, data, strb, bdelay, r, lat);
        if (in_range) model_write(addr, data, strb);
        if (r !== exp_resp) report_mismatch("bresp", exp_resp, r);
        if (lat != exp_lat) report_mismatch("write latency", exp_lat, lat);
    endtask

    task automatic read_check(input addr_t addr, input bit in_range, input int rdelay);
        data_t d;
        resp_t r;
        int    lat;
        data_t exp_data;
        resp_t exp_resp;
        int    exp_lat;
        exp_data = in_range ? model_read(addr) : '0;
        exp_resp = in_range ? RESP_OKAY : RESP_DECERR;
        exp_lat  = in_range ? 2 : 1;
        axi_read(addr, rdelay, d, r, lat);
        if (d !== exp_data) report_mismatch("rdata", exp_data, d);
        if (r !== exp_resp) report_mismatch("rresp", exp_resp, r);
        if (lat != exp_lat) report_mismatch("read latency", exp_lat, lat);
    endtask

    task automatic test_reset_state();
        test_name = "reset_state";
        tests_run++;
        if (saxi_rvalid !== 1'b0) report_mismatch("rvalid", 0, saxi_rvalid);
        if (saxi_bvalid !== 1'b0) report_mismatch("bvalid", 0, saxi_bvalid);
        if (saxi_arready !== 1'b1) report_mismatch("arready", 1, saxi_arready);
        if (saxi_awready !== 1'b1) report_mismatch("awready", 1, saxi_awready);
        if (saxi_wready !== 1'b0) report_mismatch("wready", 0, saxi_wready);
    endtask

    // every word of the region covers all banks and all rows
    task automatic test_full_words();
        test_name = "full_words";
        tests_run++;
        for (int i = 0; i < NUM_WORDS; i++) begin
            write_check(REGION_BASE + 4 * i, $random(seed), 4'hf, 1'b1, 0);
        end
        for (int i = 0; i < NUM_WORDS; i++) begin
            read_check(REGION_BASE + 4 * i, 1'b1, 0);
        end
    endtask

    task automatic test_strobes();
        addr_t a;
        test_name = "strobes";
        tests_run++;
        a = REGION_BASE + 32'h14;
        for (int s = 0; s < 16; s++) begin
            write_check(a, 32'h1234_5678, 4'hf, 1'b1, 0);
            write_check(a, $random(seed), strb_t'(s), 1'b1, 0);
            read_check(a, 1'b1, 0);
        end
    endtask

    task automatic test_backpressure();
        test_name = "backpressure";
        tests_run++;
        read_check(REGION_BASE + 32'h20, 1'b1, 5);
        // read on bank 0 and write on bank 1 in flight together
        fork
            read_check(REGION_BASE + 32'h40, 1'b1, 6);
            write_check(REGION_BASE + 32'h44, 32'hdead_beef, 4'hf, 1'b1, 6);
        join
        read_check(REGION_BASE + 32'h44, 1'b1, 0);
    endtask

    task automatic test_out_of_range();
        addr_t top;
        test_name = "out_of_range";
        tests_run++;
        top = REGION_BASE + 4 * NUM_WORDS;
        write_check(REGION_BASE - 4, 32'h0bad_0bad, 4'hf, 1'b0, 0);
        read_check(REGION_BASE - 4, 1'b0, 0);
        write_check(top, 32'hbad0_bad0, 4'hf, 1'b0, 2);
        read_check(top, 1'b0, 2);
        // words a wrapped index would land on
        read_check(REGION_BASE, 1'b1, 0);
        read_check(top - 4, 1'b1, 0);
    endtask

    task automatic test_random();
        addr_t a;
        data_t d;
        strb_t s;
        int    dly;
        test_name = "random";
        tests_run++;
        for (int i = 0; i < 200; i++) begin
            a   = REGION_BASE + 4 * ($unsigned($random(seed)) % NUM_WORDS);
            d   = $random(seed);
            s   = $random(seed);
            dly = $unsigned($random(seed)) % 4;
            write_check(a, d, s, 1'b1, dly);
            a   = REGION_BASE + 4 * ($unsigned($random(seed)) % NUM_WORDS);
            dly = $unsigned($random(seed)) % 4;
            read_check(a, 1'b1, dly);
        end
    endtask

    // a stuck handshake ends the run here
    initial begin
        @(timed_out);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        seed         = 32'h7777_cd87;
        errors       = 0;
        tests_run    = 0;
        test_name    = "init";
        clk          = 1'b0;
        rst          = 1'b1;
        saxi_araddr  = '0;
        saxi_arvalid = 1'b0;
        saxi_rready  = 1'b0;
        saxi_awaddr  = '0;
        saxi_awvalid = 1'b0;
        saxi_wdata   = '0;
        saxi_wstrb   = '0;
        saxi_wvalid  = 1'b0;
        saxi_bready  = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_reset_state();
        test_full_words();
        test_strobes();
        test_backpressure();
        test_out_of_range();
        test_random();
        repeat (4) @(posedge clk);
        $display("tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
